// File: design/lsu_pkg.sv
// -------------------------------------------------
// Shared widths, encodings and micro-op layout for
// the load pipeline. Addresses are 32 bits and there
// is no translation, so the virtual address is the
// physical address.
// -------------------------------------------------

package lsu_pkg;

  // Datapath widths
  localparam int XLEN_W    = 64;
  localparam int ADDR_W    = 32;
  localparam int CMT_ID_W  = 6;
  localparam int REG_IDX_W = 5;
  localparam int DW_BYTE_W = 3;
  localparam int IMM_W     = 12;

  // Major opcodes and the FENCE.I minor code
  localparam logic [6:0] OPCODE_LOAD     = 7'b0000011;
  localparam logic [6:0] OPCODE_MISC_MEM = 7'b0001111;
  localparam logic [2:0] FUNCT3_FENCE_I  = 3'b001;

  typedef enum logic [1:0] {
    OP_LOAD    = 2'd0,
    OP_FENCE_I = 2'd1,
    OP_ILLEGAL = 2'd2
  } op_t;

  // Encoded as funct3[1:0] of the load instructions
  typedef enum logic [1:0] {
    SIZE_B  = 2'd0,
    SIZE_H  = 2'd1,
    SIZE_W  = 2'd2,
    SIZE_DW = 2'd3
  } size_t;

  // Values follow the RISC-V mcause exception codes
  typedef enum logic [3:0] {
    EXC_NONE          = 4'd0,
    EXC_ILLEGAL_INST  = 4'd2,
    EXC_LOAD_MISALIGN = 4'd4
  } except_t;

  typedef struct packed {
    logic [CMT_ID_W-1:0]  cmt_id;
    logic [REG_IDX_W-1:0] rd_idx;
    op_t                  op;
    size_t                size;
    logic                 is_signed;
    logic [IMM_W-1:0]     imm;
  } uop_t;

endpackage

// File: design/lsu_stage_if.sv
// -------------------------------------------------
// One pipeline register slot between two stages.
// No handshake: a valid slot always advances on the
// next clock edge.
// -------------------------------------------------

`timescale 1ns/1ps

interface lsu_stage_if;

  logic                        valid;
  lsu_pkg::uop_t               uop;
  logic [lsu_pkg::ADDR_W-1:0]  addr;
  logic                        except_valid;
  lsu_pkg::except_t            except_type;
  // Extended load result that is only meaningful after EX2
  logic [lsu_pkg::XLEN_W-1:0]  data;

  modport src (
    output valid, uop, addr, except_valid, except_type, data
  );

  modport dst (
    input valid, uop, addr, except_valid, except_type, data
  );

endinterface

// File: design/lsu_ex0_decode.sv
// -------------------------------------------------
// EX0 stage. Decodes LB/LH/LW/LD/LBU/LHU/LWU and
// FENCE.I. Every other encoding becomes OP_ILLEGAL.
// The base address is kept as rs1 truncated to
// ADDR_W. The offset is added in EX1.
// -------------------------------------------------

`timescale 1ns/1ps

module lsu_ex0_decode (
  input  logic                           i_clk,
  input  logic                           i_reset_n,
  input  logic                           i_flush,
  input  logic                           i_issue_valid,
  input  logic [31:0]                    i_inst,
  input  logic [lsu_pkg::XLEN_W-1:0]     i_rs1_data,
  input  logic [lsu_pkg::CMT_ID_W-1:0]   i_cmt_id,
  input  logic [lsu_pkg::REG_IDX_W-1:0]  i_rd_idx,
  lsu_stage_if.src                       o_ex1
);

  logic [6:0]    w_opcode;
  logic [2:0]    w_funct3;
  lsu_pkg::uop_t w_uop;

  assign w_opcode = i_inst[6:0];
  assign w_funct3 = i_inst[14:12];

  // Decode
  always_comb begin
    w_uop.cmt_id    = i_cmt_id;
    w_uop.rd_idx    = i_rd_idx;
    w_uop.imm       = i_inst[31:20];
    w_uop.op        = lsu_pkg::OP_ILLEGAL;
    w_uop.size      = lsu_pkg::SIZE_B;
    w_uop.is_signed = 1'b0;
    // funct3 of 7 would be an unsigned LD, which does not exist
    if ((w_opcode == lsu_pkg::OPCODE_LOAD) && (w_funct3 != 3'b111)) begin
      w_uop.op        = lsu_pkg::OP_LOAD;
      w_uop.size      = lsu_pkg::size_t'(w_funct3[1:0]);
      w_uop.is_signed = ~w_funct3[2];
    end else if ((w_opcode == lsu_pkg::OPCODE_MISC_MEM) &&
                 (w_funct3 == lsu_pkg::FUNCT3_FENCE_I)) begin
      w_uop.op = lsu_pkg::OP_FENCE_I;
    end
  end

  // EX1 slot
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ex1.valid <= 1'b0;
    end else begin
      o_ex1.valid <= i_issue_valid & ~i_flush;
    end
  end

  always_ff @(posedge i_clk) begin
    o_ex1.uop  <= w_uop;
    o_ex1.addr <= i_rs1_data[lsu_pkg::ADDR_W-1:0];
  end

  // Exception and data fields are filled in by later stages
  assign o_ex1.except_valid = 1'b0;
  assign o_ex1.except_type  = lsu_pkg::EXC_NONE;
  assign o_ex1.data         = '0;

endmodule

// File: design/lsu_ex1_agen.sv
// -------------------------------------------------
// EX1 stage. Adds the sign-extended I-type offset,
// checks natural alignment and issues a doubleword
// read. Memory answers one cycle later, while the
// operation sits in EX2.
// -------------------------------------------------

`timescale 1ns/1ps

module lsu_ex1_agen (
  input  logic                         i_clk,
  input  logic                         i_reset_n,
  input  logic                         i_flush,
  lsu_stage_if.dst                     i_ex1,
  lsu_stage_if.src                     o_ex2,
  output logic                         o_mem_req,
  output logic [lsu_pkg::ADDR_W-1:0]   o_mem_addr
);

  logic [lsu_pkg::ADDR_W-1:0] w_imm_ext;
  logic [lsu_pkg::ADDR_W-1:0] w_addr;
  logic                       w_misaligned;
  logic                       w_is_load;

  assign w_imm_ext = {{(lsu_pkg::ADDR_W-lsu_pkg::IMM_W){i_ex1.uop.imm[lsu_pkg::IMM_W-1]}},
                      i_ex1.uop.imm};
  assign w_addr    = i_ex1.addr + w_imm_ext;
  assign w_is_load = (i_ex1.uop.op == lsu_pkg::OP_LOAD);

  always_comb begin
    case (i_ex1.uop.size)
      lsu_pkg::SIZE_H:  w_misaligned = w_addr[0];
      lsu_pkg::SIZE_W:  w_misaligned = |w_addr[1:0];
      lsu_pkg::SIZE_DW: w_misaligned = |w_addr[2:0];
      default:          w_misaligned = 1'b0;
    endcase
  end

  // Memory read request
  assign o_mem_req  = i_ex1.valid & w_is_load & ~w_misaligned & ~i_flush;
  assign o_mem_addr = {w_addr[lsu_pkg::ADDR_W-1:lsu_pkg::DW_BYTE_W], {lsu_pkg::DW_BYTE_W{1'b0}}};

  // EX2 slot
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ex2.valid <= 1'b0;
    end else begin
      o_ex2.valid <= i_ex1.valid & ~i_flush;
    end
  end

  always_ff @(posedge i_clk) begin
    o_ex2.uop          <= i_ex1.uop;
    o_ex2.addr         <= w_addr;
    o_ex2.except_valid <= (w_is_load & w_misaligned) | (i_ex1.uop.op == lsu_pkg::OP_ILLEGAL);
    if (i_ex1.uop.op == lsu_pkg::OP_ILLEGAL) begin
      o_ex2.except_type <= lsu_pkg::EXC_ILLEGAL_INST;
    end else if (w_is_load & w_misaligned) begin
      o_ex2.except_type <= lsu_pkg::EXC_LOAD_MISALIGN;
    end else begin
      o_ex2.except_type <= lsu_pkg::EXC_NONE;
    end
  end

  assign o_ex2.data = '0;

endmodule

// File: design/lsu_ex2_align.sv
// -------------------------------------------------
// EX2 stage. Takes the doubleword returned this
// cycle, with no tag, so the memory latency must be
// exactly one cycle. Selects the addressed bytes and
// extends them to XLEN.
// -------------------------------------------------

`timescale 1ns/1ps

module lsu_ex2_align (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  logic                        i_flush,
  input  logic [lsu_pkg::XLEN_W-1:0]  i_mem_rdata,
  lsu_stage_if.dst                    i_ex2,
  lsu_stage_if.src                    o_ex3
);

  logic [lsu_pkg::DW_BYTE_W+2:0] w_shift_amt;
  logic [lsu_pkg::XLEN_W-1:0]    w_shifted;
  logic [lsu_pkg::XLEN_W-1:0]    w_ext_data;
  logic                          w_sign;

  // Byte offset times eight
  assign w_shift_amt = {i_ex2.addr[lsu_pkg::DW_BYTE_W-1:0], 3'b000};
  assign w_shifted   = i_mem_rdata >> w_shift_amt;

  // --------------------------------------------------
  // Size mask and sign or zero extension
  // --------------------------------------------------
  always_comb begin
    case (i_ex2.uop.size)
      lsu_pkg::SIZE_B: begin
        w_sign     = i_ex2.uop.is_signed & w_shifted[7];
        w_ext_data = {{(lsu_pkg::XLEN_W-8){w_sign}}, w_shifted[7:0]};
      end
      lsu_pkg::SIZE_H: begin
        w_sign     = i_ex2.uop.is_signed & w_shifted[15];
        w_ext_data = {{(lsu_pkg::XLEN_W-16){w_sign}}, w_shifted[15:0]};
      end
      lsu_pkg::SIZE_W: begin
        w_sign     = i_ex2.uop.is_signed & w_shifted[31];
        w_ext_data = {{(lsu_pkg::XLEN_W-32){w_sign}}, w_shifted[31:0]};
      end
      default: begin
        w_sign     = 1'b0;
        w_ext_data = w_shifted;
      end
    endcase
  end

  // EX3 slot
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ex3.valid <= 1'b0;
    end else begin
      o_ex3.valid <= i_ex2.valid & ~i_flush;
    end
  end

  always_ff @(posedge i_clk) begin
    o_ex3.uop          <= i_ex2.uop;
    o_ex3.addr         <= i_ex2.addr;
    o_ex3.except_valid <= i_ex2.except_valid;
    o_ex3.except_type  <= i_ex2.except_type;
    o_ex3.data         <= w_ext_data;
  end

endmodule

// File: design/lsu_ex3_complete.sv
// -------------------------------------------------
// EX3 stage. Registers completion, exception and
// register write. A completed FENCE.I waits for the
// commit of its own cmt_id, then o_fence_i pulses
// combinationally in that commit cycle.
// -------------------------------------------------

`timescale 1ns/1ps

module lsu_ex3_complete (
  input  logic                           i_clk,
  input  logic                           i_reset_n,
  input  logic                           i_commit_valid,
  input  logic [lsu_pkg::CMT_ID_W-1:0]   i_commit_cmt_id,
  lsu_stage_if.dst                       i_ex3,
  output logic                           o_done_valid,
  output logic [lsu_pkg::CMT_ID_W-1:0]   o_done_cmt_id,
  output logic                           o_except_valid,
  output lsu_pkg::except_t               o_except_type,
  output logic [lsu_pkg::XLEN_W-1:0]     o_except_tval,
  output logic                           o_wr_valid,
  output logic [lsu_pkg::REG_IDX_W-1:0]  o_wr_idx,
  output logic [lsu_pkg::XLEN_W-1:0]     o_wr_data,
  output logic                           o_fence_i
);

  logic                          w_is_fence_i;
  logic                          w_fence_match;
  logic                          r_fence_wait;
  logic [lsu_pkg::CMT_ID_W-1:0]  r_fence_cmt_id;

  assign w_is_fence_i = i_ex3.valid & (i_ex3.uop.op == lsu_pkg::OP_FENCE_I);

  // --------------------------------------------------
  // Completion and write-back
  // --------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_done_valid   <= 1'b0;
      o_except_valid <= 1'b0;
      o_wr_valid     <= 1'b0;
    end else begin
      o_done_valid   <= i_ex3.valid;
      o_except_valid <= i_ex3.valid & i_ex3.except_valid;
      // x0 is never written
      o_wr_valid     <= i_ex3.valid & (i_ex3.uop.op == lsu_pkg::OP_LOAD) &
                        ~i_ex3.except_valid & (i_ex3.uop.rd_idx != '0);
    end
  end

  always_ff @(posedge i_clk) begin
    o_done_cmt_id <= i_ex3.uop.cmt_id;
    o_except_type <= i_ex3.except_type;
    o_wr_idx      <= i_ex3.uop.rd_idx;
    o_wr_data     <= i_ex3.data;
    if (i_ex3.except_type == lsu_pkg::EXC_LOAD_MISALIGN) begin
      o_except_tval <= {{(lsu_pkg::XLEN_W-lsu_pkg::ADDR_W){1'b0}}, i_ex3.addr};
    end else begin
      o_except_tval <= '0;
    end
  end

  // --------------------------------------------------
  // FENCE.I commit wait
  // --------------------------------------------------
  assign w_fence_match = r_fence_wait & i_commit_valid & (i_commit_cmt_id == r_fence_cmt_id);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_fence_wait <= 1'b0;
    end else if (w_fence_match) begin
      r_fence_wait <= 1'b0;
    end else if (w_is_fence_i) begin
      r_fence_wait <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!w_fence_match && w_is_fence_i) begin
      r_fence_cmt_id <= i_ex3.uop.cmt_id;
    end
  end

  assign o_fence_i = w_fence_match;

endmodule

// File: design/lsu_pipe_top.sv
// -------------------------------------------------
// Four-stage load pipeline, EX0 to EX3. Completion
// comes three cycles after the issue edge. Memory
// must answer one cycle after o_mem_req. There is
// no back-pressure on any port.
// -------------------------------------------------

`timescale 1ns/1ps

module lsu_pipe_top (
  input  logic                           i_clk,
  input  logic                           i_reset_n,
  input  logic                           i_issue_valid,
  input  logic [31:0]                    i_inst,
  input  logic [lsu_pkg::XLEN_W-1:0]     i_rs1_data,
  input  logic [lsu_pkg::CMT_ID_W-1:0]   i_cmt_id,
  input  logic [lsu_pkg::REG_IDX_W-1:0]  i_rd_idx,
  input  logic                           i_flush,
  input  logic                           i_commit_valid,
  input  logic [lsu_pkg::CMT_ID_W-1:0]   i_commit_cmt_id,
  input  logic [lsu_pkg::XLEN_W-1:0]     i_mem_rdata,
  output logic                           o_mem_req,
  output logic [lsu_pkg::ADDR_W-1:0]     o_mem_addr,
  output logic                           o_done_valid,
  output logic [lsu_pkg::CMT_ID_W-1:0]   o_done_cmt_id,
  output logic                           o_except_valid,
  output lsu_pkg::except_t               o_except_type,
  output logic [lsu_pkg::XLEN_W-1:0]     o_except_tval,
  output logic                           o_wr_valid,
  output logic [lsu_pkg::REG_IDX_W-1:0]  o_wr_idx,
  output logic [lsu_pkg::XLEN_W-1:0]     o_wr_data,
  output logic                           o_fence_i
);

  // Stage slots
  lsu_stage_if ex1_if ();
  lsu_stage_if ex2_if ();
  lsu_stage_if ex3_if ();

  lsu_ex0_decode u_ex0 (
    .i_clk (i_clk), .i_reset_n (i_reset_n), .i_flush (i_flush),
    .i_issue_valid (i_issue_valid), .i_inst (i_inst), .i_rs1_data (i_rs1_data),
    .i_cmt_id (i_cmt_id), .i_rd_idx (i_rd_idx), .o_ex1 (ex1_if.src)
  );

  lsu_ex1_agen u_ex1 (
    .i_clk (i_clk), .i_reset_n (i_reset_n), .i_flush (i_flush),
    .i_ex1 (ex1_if.dst), .o_ex2 (ex2_if.src),
    .o_mem_req (o_mem_req), .o_mem_addr (o_mem_addr)
  );

  lsu_ex2_align u_ex2 (
    .i_clk (i_clk), .i_reset_n (i_reset_n), .i_flush (i_flush),
    .i_mem_rdata (i_mem_rdata), .i_ex2 (ex2_if.dst), .o_ex3 (ex3_if.src)
  );

  lsu_ex3_complete u_ex3 (
    .i_clk (i_clk), .i_reset_n (i_reset_n),
    .i_commit_valid (i_commit_valid), .i_commit_cmt_id (i_commit_cmt_id),
    .i_ex3 (ex3_if.dst),
    .o_done_valid (o_done_valid), .o_done_cmt_id (o_done_cmt_id),
    .o_except_valid (o_except_valid), .o_except_type (o_except_type),
    .o_except_tval (o_except_tval), .o_wr_valid (o_wr_valid),
    .o_wr_idx (o_wr_idx), .o_wr_data (o_wr_data), .o_fence_i (o_fence_i)
  );

endmodule

// File: tb/lsu_pipe_checker.sv
// -------------------------------------------------
// Protocol properties of the load pipeline outputs.
// Bound into lsu_pipe_top, sampled on i_clk and
// ignored while reset is asserted.
// -------------------------------------------------

`timescale 1ns/1ps

module lsu_pipe_checker (
  input logic                               i_clk,
  input logic                               i_reset_n,
  input logic                               i_mem_req,
  input logic [lsu_pkg::ADDR_W-1:0]         i_mem_addr,
  input logic                               i_done_valid,
  input logic                               i_except_valid,
  input logic                               i_wr_valid,
  input logic [lsu_pkg::REG_IDX_W-1:0]      i_wr_idx
);

  // Requests are always doubleword aligned
  a_req_aligned : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_mem_req |-> (i_mem_addr[lsu_pkg::DW_BYTE_W-1:0] == '0))
    else $error("memory request address not doubleword aligned");

  a_wr_done : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_wr_valid |-> (i_done_valid && (i_wr_idx != '0)))
    else $error("register write without completion or to x0");

  a_wr_except : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_wr_valid && i_except_valid))
    else $error("register write together with an exception");

endmodule

bind lsu_pipe_top lsu_pipe_checker u_checker (
  .i_clk (i_clk), .i_reset_n (i_reset_n),
  .i_mem_req (o_mem_req), .i_mem_addr (o_mem_addr),
  .i_done_valid (o_done_valid), .i_except_valid (o_except_valid),
  .i_wr_valid (o_wr_valid), .i_wr_idx (o_wr_idx)
);

// File: tb/lsu_pipe_tb.sv
// -------------------------------------------------
// Table-driven testbench for the load pipeline.
// Cycle numbers count rising edges after reset.
// Memory answers one cycle after each request.
// -------------------------------------------------

`timescale 1ns/1ps

module lsu_pipe_tb;

  localparam int NUM_ROWS = 23;

  typedef struct {
    logic [31:0] inst;
    logic [63:0] rs1;
    logic [5:0]  cmt_id;
    logic [4:0]  rd;
    int          issue;
    int          flush;
    int          commit;
    logic [5:0]  commit_id;
    logic [3:0]  exp_exc;
    logic        exp_wr;
    logic [63:0] exp_data;
    logic [63:0] exp_tval;
    logic        exp_req;
    logic [31:0] exp_addr;
    logic        is_fence;
  } row_t;

  logic        i_clk = 1'b0;
  logic        i_reset_n = 1'b0;
  logic        i_issue_valid = 1'b0;
  logic [31:0] i_inst = '0;
  logic [63:0] i_rs1_data = '0;
  logic [5:0]  i_cmt_id = '0;
  logic [4:0]  i_rd_idx = '0;
  logic        i_flush = 1'b0;
  logic        i_commit_valid = 1'b0;
  logic [5:0]  i_commit_cmt_id = '0;
  logic [63:0] i_mem_rdata = '0;
  logic        o_mem_req;
  logic [31:0] o_mem_addr;
  logic        o_done_valid;
  logic [5:0]  o_done_cmt_id;
  logic        o_except_valid;
  logic [3:0]  o_except_type;
  logic [63:0] o_except_tval;
  logic        o_wr_valid;
  logic [4:0]  o_wr_idx;
  logic [63:0] o_wr_data;
  logic        o_fence_i;

  row_t tbl [NUM_ROWS];
  int   row_err [NUM_ROWS];
  bit   fence_pending [NUM_ROWS];
  int   cyc = 0;
  int   last_cycle = 0;
  int   finished = 0;
  int   failed = 0;
  int   global_err = 0;

  lsu_pipe_top uut (
    .i_clk (i_clk), .i_reset_n (i_reset_n), .i_issue_valid (i_issue_valid),
    .i_inst (i_inst), .i_rs1_data (i_rs1_data), .i_cmt_id (i_cmt_id),
    .i_rd_idx (i_rd_idx), .i_flush (i_flush), .i_commit_valid (i_commit_valid),
    .i_commit_cmt_id (i_commit_cmt_id), .i_mem_rdata (i_mem_rdata),
    .o_mem_req (o_mem_req), .o_mem_addr (o_mem_addr), .o_done_valid (o_done_valid),
    .o_done_cmt_id (o_done_cmt_id), .o_except_valid (o_except_valid),
    .o_except_type (o_except_type), .o_except_tval (o_except_tval),
    .o_wr_valid (o_wr_valid), .o_wr_idx (o_wr_idx), .o_wr_data (o_wr_data),
    .o_fence_i (o_fence_i)
  );

  always #2 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    if (!i_reset_n) cyc <= 0;
    else cyc <= cyc + 1;
  end

  // Memory model returns the address in the low half and a scrambled copy above it
  always @(posedge i_clk) begin
    if (o_mem_req) i_mem_rdata <= {o_mem_addr ^ 32'hA5A5_5A5A, o_mem_addr};
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] load_inst(input logic [2:0] f3, input logic [11:0] imm);
    return {imm, 5'd1, f3, 5'd0, 7'b0000011};
  endfunction

  // Expected results from the RISC-V load rules and the memory model
  task automatic add_row(input int idx, input logic [31:0] inst, input logic [63:0] rs1,
                         input logic [4:0] rd, input int issue, input int flush,
                         input int commit, input logic [5:0] commit_id);
    logic [2:0]  f3;
    logic [31:0] a;
    logic [63:0] dw;
    logic [63:0] sh;
    logic        is_load;
    logic        mis;
    f3      = inst[14:12];
    is_load = (inst[6:0] == 7'b0000011) && (f3 != 3'd7);
    a       = rs1[31:0] + {{20{inst[31]}}, inst[31:20]};
    case (f3[1:0])
      2'd1: mis = a[0];
      2'd2: mis = |a[1:0];
      2'd3: mis = |a[2:0];
      default: mis = 1'b0;
    endcase
    tbl[idx] = '{inst, rs1, 6'(idx + 1), rd, issue, flush, commit, commit_id,
                 4'd0, 1'b0, 64'd0, 64'd0, 1'b0, {a[31:3], 3'b000}, 1'b0};
    tbl[idx].is_fence = (inst[6:0] == 7'b0001111) && (f3 == 3'd1);
    if (!is_load && !tbl[idx].is_fence) begin
      tbl[idx].exp_exc = 4'd2;
    end else if (is_load && mis) begin
      tbl[idx].exp_exc  = 4'd4;
      tbl[idx].exp_tval = {32'd0, a};
    end else if (is_load) begin
      tbl[idx].exp_req = 1'b1;
      tbl[idx].exp_wr  = (rd != 5'd0);
      dw = {tbl[idx].exp_addr ^ 32'hA5A5_5A5A, tbl[idx].exp_addr};
      sh = dw >> {a[2:0], 3'b000};
      case (f3)
        3'd0: tbl[idx].exp_data = {{56{sh[7]}}, sh[7:0]};
        3'd1: tbl[idx].exp_data = {{48{sh[15]}}, sh[15:0]};
        3'd2: tbl[idx].exp_data = {{32{sh[31]}}, sh[31:0]};
        3'd4: tbl[idx].exp_data = {56'd0, sh[7:0]};
        3'd5: tbl[idx].exp_data = {48'd0, sh[15:0]};
        3'd6: tbl[idx].exp_data = {32'd0, sh[31:0]};
        default: tbl[idx].exp_data = sh;
      endcase
    end
    fence_pending[idx] = tbl[idx].is_fence;
    if (issue + 4 > last_cycle) last_cycle = issue + 4;
    if (commit > last_cycle) last_cycle = commit;
  endtask

  function automatic bit killed(input int idx, input int span);
    for (int k = 0; k < NUM_ROWS; k++) begin
      if (tbl[k].flush >= tbl[idx].issue && tbl[k].flush <= tbl[idx].issue + span) return 1;
    end
    return 0;
  endfunction

  task automatic report_mismatch(input int idx, input string name,
                                 input logic [63:0] got, input logic [63:0] exp);
    $display("** Error: test %0d %s = 0x%h, expected 0x%h", idx, name, got, exp);
    row_err[idx]++;
  endtask

  task automatic finish_row(input int idx);
    finished++;
    if (row_err[idx] != 0) failed++;
    $display("test %0d %s", idx, (row_err[idx] == 0) ? "passed" : "failed");
  endtask

  // ----------------------------------------------
  // Output monitor half a cycle after each edge
  // ----------------------------------------------
  always begin : monitor
    logic exp_req;
    logic exp_fence;
    int   fence_row;
    @(negedge i_clk);
    #1;
    if (i_reset_n) begin
      exp_fence = 1'b0;
      fence_row = -1;
      for (int i = 0; i < NUM_ROWS; i++) begin
        if (cyc == tbl[i].issue + 1) begin
          exp_req = tbl[i].exp_req && !killed(i, 1);
          if (o_mem_req !== exp_req)
            report_mismatch(i, "o_mem_req", 64'(o_mem_req), 64'(exp_req));
          if (exp_req && o_mem_addr !== tbl[i].exp_addr)
            report_mismatch(i, "o_mem_addr", 64'(o_mem_addr), 64'(tbl[i].exp_addr));
        end
        if (cyc == tbl[i].issue + 4) begin
          if (killed(i, 2)) begin
            if (o_done_valid !== 1'b0)
              report_mismatch(i, "o_done_valid", 64'(o_done_valid), 64'd0);
            fence_pending[i] = 1'b0;
          end else begin
            if (o_done_valid !== 1'b1)
              report_mismatch(i, "o_done_valid", 64'(o_done_valid), 64'd1);
            if (o_done_cmt_id !== tbl[i].cmt_id)
              report_mismatch(i, "o_done_cmt_id", 64'(o_done_cmt_id), 64'(tbl[i].cmt_id));
            if (o_except_valid !== (tbl[i].exp_exc != 4'd0))
              report_mismatch(i, "o_except_valid", 64'(o_except_valid),
                              64'(tbl[i].exp_exc != 4'd0));
            if (tbl[i].exp_exc != 4'd0 && o_except_type !== tbl[i].exp_exc)
              report_mismatch(i, "o_except_type", 64'(o_except_type), 64'(tbl[i].exp_exc));
            if (tbl[i].exp_exc != 4'd0 && o_except_tval !== tbl[i].exp_tval)
              report_mismatch(i, "o_except_tval", o_except_tval, tbl[i].exp_tval);
            if (o_wr_valid !== tbl[i].exp_wr)
              report_mismatch(i, "o_wr_valid", 64'(o_wr_valid), 64'(tbl[i].exp_wr));
            if (tbl[i].exp_wr && o_wr_idx !== tbl[i].rd)
              report_mismatch(i, "o_wr_idx", 64'(o_wr_idx), 64'(tbl[i].rd));
            if (tbl[i].exp_wr && o_wr_data !== tbl[i].exp_data)
              report_mismatch(i, "o_wr_data", o_wr_data, tbl[i].exp_data);
          end
          if (!fence_pending[i]) finish_row(i);
        end
        if (tbl[i].commit == cyc) begin
          for (int j = 0; j < NUM_ROWS; j++) begin
            if (fence_pending[j] && tbl[j].cmt_id == tbl[i].commit_id &&
                tbl[j].issue + 4 <= cyc) begin
              exp_fence = 1'b1;
              fence_row = j;
            end
          end
        end
      end
      if (o_fence_i !== exp_fence) begin
        if (fence_row >= 0) begin
          report_mismatch(fence_row, "o_fence_i", 64'(o_fence_i), 64'(exp_fence));
        end else begin
          $display("** Error: cycle %0d o_fence_i = 0x%h, expected 0x%h",
                   cyc, o_fence_i, exp_fence);
          global_err++;
        end
      end
      if (fence_row >= 0) begin
        fence_pending[fence_row] = 1'b0;
        finish_row(fence_row);
      end
    end
  end

  initial begin : watchdog
    repeat (NUM_ROWS * 10 + 100) @(posedge i_clk);
    $display("Watchdog expired before all tests finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin : main
    logic [31:0] seed;
    logic [2:0]  f3;
    seed = 32'he800_6740;
    // Back-to-back aligned loads with sign bits set in the upper half
    add_row(0, load_inst(3'd0, 12'd6), 64'h0000_0000_1000_0000, 5'd1, 2, -10, -10, 6'd0);
    add_row(1, load_inst(3'd1, 12'hFF6), 64'h0000_0000_1000_0010, 5'd2, 3, -10, -10, 6'd0);
    add_row(2, load_inst(3'd2, 12'd4), 64'hFFFF_0000_2000_0000, 5'd3, 4, -10, -10, 6'd0);
    add_row(3, load_inst(3'd3, 12'd8), 64'h0000_0000_3000_0000, 5'd4, 5, -10, -10, 6'd0);
    add_row(4, load_inst(3'd4, 12'd7), 64'h0000_0000_1000_0000, 5'd5, 6, -10, -10, 6'd0);
    add_row(5, load_inst(3'd5, 12'd6), 64'h0000_0000_1000_0000, 5'd6, 7, -10, -10, 6'd0);
    add_row(6, load_inst(3'd6, 12'd4), 64'h0000_0000_4000_0000, 5'd7, 8, -10, -10, 6'd0);
    // Misaligned LH, LW, LD
    add_row(7, load_inst(3'd1, 12'd1), 64'h0000_0000_1000_0000, 5'd8, 10, -10, -10, 6'd0);
    add_row(8, load_inst(3'd2, 12'd2), 64'h0000_0000_1000_0000, 5'd9, 11, -10, -10, 6'd0);
    add_row(9, load_inst(3'd3, 12'd4), 64'h0000_0000_1000_0000, 5'd10, 12, -10, -10, 6'd0);
    // x0 destination and an unsupported store encoding
    add_row(10, load_inst(3'd3, 12'd0), 64'h0000_0000_5000_0000, 5'd0, 14, -10, -10, 6'd0);
    add_row(11, 32'h0000_3023, 64'h0000_0000_5000_0000, 5'd11, 15, -10, -10, 6'd0);
    // Flush one and two cycles after issue and then a normal load
    add_row(12, load_inst(3'd3, 12'd0), 64'h0000_0000_6000_0000, 5'd12, 18, 19, -10, 6'd0);
    add_row(13, load_inst(3'd3, 12'd0), 64'h0000_0000_6000_0008, 5'd13, 22, 24, -10, 6'd0);
    add_row(14, load_inst(3'd2, 12'd4), 64'h0000_0000_6000_0010, 5'd14, 25, -10, -10, 6'd0);
    // FENCE.I sees a commit of another id before its own
    add_row(15, 32'h0000_100F, 64'd0, 5'd15, 28, -10, 36, 6'd16);
    add_row(16, load_inst(3'd0, 12'd3), 64'h0000_0000_7000_0000, 5'd16, 29, -10, 34, 6'd17);
    for (int i = 17; i < NUM_ROWS; i++) begin
      seed = lcg_next(seed);
      f3 = (seed[18:16] == 3'd7) ? 3'd3 : seed[18:16];
      add_row(i, load_inst(f3, {4'd0, seed[31:24]}), {32'd0, seed}, 5'(i), 40 + i - 17,
              -10, -10, 6'd0);
    end
    repeat (3) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;
    while (cyc <= last_cycle + 1) begin
      @(negedge i_clk);
      i_issue_valid  = 1'b0;
      i_flush        = 1'b0;
      i_commit_valid = 1'b0;
      for (int i = 0; i < NUM_ROWS; i++) begin
        if (tbl[i].issue == cyc) begin
          i_issue_valid = 1'b1;
          i_inst        = tbl[i].inst;
          i_rs1_data    = tbl[i].rs1;
          i_cmt_id      = tbl[i].cmt_id;
          i_rd_idx      = tbl[i].rd;
        end
        if (tbl[i].flush == cyc) i_flush = 1'b1;
        if (tbl[i].commit == cyc) begin
          i_commit_valid  = 1'b1;
          i_commit_cmt_id = tbl[i].commit_id;
        end
      end
    end
    repeat (2) @(negedge i_clk);
    if (finished != NUM_ROWS) $display("Only %0d of %0d tests finished", finished, NUM_ROWS);
    $display("tests %0d, passed %0d, failed %0d, other errors %0d",
             NUM_ROWS, finished - failed, failed, global_err);
    if (failed == 0 && global_err == 0 && finished == NUM_ROWS) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog.f
design/lsu_pkg.sv
design/lsu_stage_if.sv
design/lsu_ex0_decode.sv
design/lsu_ex1_agen.sv
design/lsu_ex2_align.sv
design/lsu_ex3_complete.sv
design/lsu_pipe_top.sv
tb/lsu_pipe_checker.sv
tb/lsu_pipe_tb.sv

// File: run.sh
#!/bin/bash
# Build with Verilator, run, then decide pass or fail from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  -f verilog.f --top-module lsu_pipe_tb -o sim_lsu > build.log 2>&1 &&
./obj_dir/sim_lsu > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "TEST RESULT: FAIL" sim.log &&
{ echo "Simulation reported failure"; exit 1; } ||
{ echo "Simulation finished cleanly"; exit 0; }
